// File: logic/csi_fabric_pkg.sv
/*
 * Fabric segment and capsule header definitions for the upstream encoder.
 * Encoders and the top level refer to these by scoped names.
 */
package csi_fabric_pkg;

    // One fabric segment on the wire
    localparam int SEG_W = 320;

    // Capsule header, placed in the low bits of segment 0
    localparam int HDR_W = 224;

    // Payload bits that share segment 0 with the header
    localparam int SOP_DATA_W = SEG_W - HDR_W;

    typedef logic [SEG_W-1:0] seg_t;
    typedef logic [HDR_W-1:0] hdr_t;

endpackage

// File: logic/csi_flow_pkg.sv
/*
 * Flow class codes, credit constants and encoder state encodings.
 * Shared by both encoders, the credit event interface and the ledger.
 */
package csi_flow_pkg;

    // Flow class carried with every beat
    typedef enum logic [1:0] {
        FLOW_NONE      = 2'd0,
        FLOW_CMPL      = 2'd1,
        FLOW_POSTED    = 2'd2,
        FLOW_NONPOSTED = 2'd3
    } flow_t;

    localparam int BEAT_CREDIT_W = 3;

    // Header plus minimum data, charged per one-segment beat
    localparam logic [BEAT_CREDIT_W-1:0] MIN_CAPSULE_CREDITS = 3'd2;

    // Kind of the beat held in the posted/completion input stage
    typedef enum logic [2:0] {
        PC_IDLE, PC_SOP, PC_PAYLOAD, PC_EOP, PC_SOP_EOP
    } pc_state_t;

endpackage

// File: logic/credit_event_if.sv
/*
 * Accepted-beat credit report from one encoder to the credit ledger.
 * The encoder drives it through src, the ledger samples it through dst.
 */
interface credit_event_if #(
    parameter int CREDIT_W = 13
);

    logic                                  fire;
    csi_flow_pkg::flow_t                   flow;
    logic                                  first;
    logic                                  last;
    logic [csi_flow_pkg::BEAT_CREDIT_W-1:0] credits;

    // Beat charge widened to the ledger counter size
    logic [CREDIT_W-1:0]                   credits_ext;

    assign credits_ext = CREDIT_W'(credits);

    modport src (output fire, flow, first, last, credits);
    modport dst (input fire, flow, first, last, credits_ext);

endinterface

// File: logic/posted_cmpl_encoder.sv
/*
 * Two-segment encoder for posted and completion capsules.
 * Inserts the capsule header into segment 0 of each start beat and reports
 * every accepted beat with its credit charge. Latency is two ready cycles.
 */
module posted_cmpl_encoder (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  csi_fabric_pkg::seg_t                   pc_data0_i,
    input  csi_fabric_pkg::seg_t                   pc_data1_i,
    input  logic [1:0]                             pc_valid_i,
    input  logic                                   pc_sop_i,
    input  logic                                   pc_eop_i,
    input  csi_flow_pkg::flow_t                    pc_flow_i,
    input  csi_fabric_pkg::hdr_t                   pc_header_i,
    input  logic [csi_flow_pkg::BEAT_CREDIT_W-1:0] pc_credits_i,
    input  logic                                   pc_rdy_i,
    output csi_fabric_pkg::seg_t                   pc_seg0_o,
    output csi_fabric_pkg::seg_t                   pc_seg1_o,
    output logic [1:0]                             pc_vld_o,
    output logic                                   pc_sop_o,
    output logic [1:0]                             pc_eop_o,
    credit_event_if.src                            evt_o
);

    csi_flow_pkg::pc_state_t                state_q;
    csi_flow_pkg::pc_state_t                state_d;
    csi_fabric_pkg::seg_t                   r_data0;
    csi_fabric_pkg::seg_t                   r_data1;
    csi_fabric_pkg::hdr_t                   r_hdr;
    csi_flow_pkg::flow_t                    r_flow;
    csi_flow_pkg::flow_t                    out_flow;
    logic [csi_flow_pkg::BEAT_CREDIT_W-1:0] r_credits;
    logic [csi_flow_pkg::BEAT_CREDIT_W-1:0] out_credits;
    logic                                   r_beat;
    logic                                   r_vld1;
    logic                                   in_beat;
    logic                                   in_capsule;
    logic                                   is_start;
    logic                                   is_end;
    logic                                   out_beat;

    // Only posted and completion traffic counts as a beat
    assign in_beat = pc_valid_i[0] &&
                     (pc_flow_i == csi_flow_pkg::FLOW_POSTED ||
                      pc_flow_i == csi_flow_pkg::FLOW_CMPL);

    assign in_capsule = (state_q == csi_flow_pkg::PC_SOP) ||
                        (state_q == csi_flow_pkg::PC_PAYLOAD);

    //////////////////////////////
    // Input stage
    //////////////////////////////

    always_comb
    begin
        state_d = csi_flow_pkg::PC_IDLE;
        if (in_beat && pc_sop_i && pc_eop_i)
            state_d = csi_flow_pkg::PC_SOP_EOP;
        else if (in_beat && pc_sop_i)
            state_d = csi_flow_pkg::PC_SOP;
        else if (in_beat && in_capsule && pc_eop_i)
            state_d = csi_flow_pkg::PC_EOP;
        else if (in_capsule)
            state_d = csi_flow_pkg::PC_PAYLOAD;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= csi_flow_pkg::PC_IDLE;
            r_beat  <= 1'b0;
        end
        else if (pc_rdy_i)
        begin
            state_q <= state_d;
            r_beat  <= in_beat;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pc_rdy_i)
        begin
            r_data0   <= pc_data0_i;
            r_data1   <= pc_data1_i;
            r_vld1    <= pc_valid_i[1];
            r_hdr     <= pc_header_i;
            r_flow    <= pc_flow_i;
            r_credits <= pc_credits_i;
        end
    end

    //////////////////////////////
    // Output stage
    //////////////////////////////

    assign is_start = (state_q == csi_flow_pkg::PC_SOP) ||
                      (state_q == csi_flow_pkg::PC_SOP_EOP);
    assign is_end   = (state_q == csi_flow_pkg::PC_EOP) ||
                      (state_q == csi_flow_pkg::PC_SOP_EOP);
    assign out_beat = r_beat && (state_q != csi_flow_pkg::PC_IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc_vld_o <= 2'b00;
            pc_sop_o <= 1'b0;
            pc_eop_o <= 2'b00;
        end
        else if (pc_rdy_i)
        begin
            pc_vld_o <= out_beat ? {r_vld1, 1'b1} : 2'b00;
            pc_sop_o <= out_beat && is_start;
            // End flag sits on the last valid segment
            pc_eop_o <= (out_beat && is_end) ? (r_vld1 ? 2'b10 : 2'b01) : 2'b00;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pc_rdy_i)
        begin
            // Header low, first payload bits above it
            pc_seg0_o   <= is_start ? {r_data0[csi_fabric_pkg::SOP_DATA_W-1:0], r_hdr}
                                    : r_data0;
            pc_seg1_o   <= r_data1;
            out_flow    <= r_flow;
            out_credits <= r_credits;
        end
    end

    // Credit report for the beat now on the outputs
    assign evt_o.fire    = pc_vld_o[0] && pc_rdy_i;
    assign evt_o.flow    = out_flow;
    assign evt_o.first   = pc_sop_o;
    assign evt_o.last    = |pc_eop_o;
    assign evt_o.credits = pc_vld_o[1] ? out_credits : csi_flow_pkg::MIN_CAPSULE_CREDITS;

endmodule

// File: logic/nonposted_encoder.sv
/*
 * Encoder for header-only non-posted capsules, one segment each.
 * Capsules appear two ready cycles after they are sampled.
 */
module nonposted_encoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csi_fabric_pkg::hdr_t np_header_i,
    input  logic                 np_sop_i,
    input  logic                 np_eop_i,
    input  logic                 np_rdy_i,
    output csi_fabric_pkg::seg_t np_seg_o,
    output logic                 np_vld_o,
    output logic                 np_sop_o,
    output logic                 np_eop_o,
    credit_event_if.src          evt_o
);

    csi_fabric_pkg::hdr_t r_hdr;
    logic                 in_flight_q;

    // A capsule is a single beat with both start and end set
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_flight_q <= 1'b0;
            np_vld_o    <= 1'b0;
        end
        else if (np_rdy_i)
        begin
            in_flight_q <= np_sop_i && np_eop_i;
            np_vld_o    <= in_flight_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (np_rdy_i)
        begin
            r_hdr <= np_header_i;
            // Header only, upper bits zero
            np_seg_o <= csi_fabric_pkg::seg_t'(r_hdr);
        end
    end

    assign np_sop_o = np_vld_o;
    assign np_eop_o = np_vld_o;

    assign evt_o.fire    = np_vld_o && np_rdy_i;
    assign evt_o.flow    = csi_flow_pkg::FLOW_NONPOSTED;
    assign evt_o.first   = np_sop_o;
    assign evt_o.last    = np_eop_o;
    assign evt_o.credits = csi_flow_pkg::MIN_CAPSULE_CREDITS;

endmodule

// File: logic/credit_ledger.sv
/*
 * Per-class credit ledger fed by the two encoder event reports.
 * Publishes each finished capsule total with a one-cycle avail pulse.
 */
module credit_ledger #(
    parameter int CREDIT_W = 13
) (
    input  logic                clk,
    input  logic                rst_n,
    credit_event_if.dst         pc_evt_i,
    credit_event_if.dst         np_evt_i,
    output logic [CREDIT_W-1:0] posted_credits_o,
    output logic [CREDIT_W-1:0] cmpl_credits_o,
    output logic [CREDIT_W-1:0] nonposted_credits_o,
    output logic                posted_avail_o,
    output logic                cmpl_avail_o,
    output logic                nonposted_avail_o
);

    // Indexed by flow code, FLOW_NONE has no slot
    logic [CREDIT_W-1:0] sum_q   [3:1];
    logic [CREDIT_W-1:0] sum_d   [3:1];
    logic [CREDIT_W-1:0] total_q [3:1];
    logic [3:1]          hit;
    logic [3:1]          hit_last;
    logic [3:1]          avail_q;

    always_comb
    begin
        for (int c = 1; c <= 3; c++)
        begin
            hit[c]      = 1'b0;
            hit_last[c] = 1'b0;
            sum_d[c]    = sum_q[c];
            if (pc_evt_i.fire && int'(pc_evt_i.flow) == c)
            begin
                hit[c]      = 1'b1;
                hit_last[c] = pc_evt_i.last;
                sum_d[c]    = pc_evt_i.first ? pc_evt_i.credits_ext
                                             : sum_q[c] + pc_evt_i.credits_ext;
            end
            else if (np_evt_i.fire && int'(np_evt_i.flow) == c)
            begin
                hit[c]      = 1'b1;
                hit_last[c] = np_evt_i.last;
                sum_d[c]    = np_evt_i.first ? np_evt_i.credits_ext
                                             : sum_q[c] + np_evt_i.credits_ext;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            avail_q <= '0;
            for (int c = 1; c <= 3; c++)
            begin
                sum_q[c]   <= '0;
                total_q[c] <= '0;
            end
        end
        else
        begin
            avail_q <= hit & hit_last;
            for (int c = 1; c <= 3; c++)
            begin
                if (hit[c])
                    sum_q[c] <= sum_d[c];
                // Capsule finished, publish its total
                if (hit[c] && hit_last[c])
                    total_q[c] <= sum_d[c];
            end
        end
    end

    assign posted_credits_o    = total_q[csi_flow_pkg::FLOW_POSTED];
    assign cmpl_credits_o      = total_q[csi_flow_pkg::FLOW_CMPL];
    assign nonposted_credits_o = total_q[csi_flow_pkg::FLOW_NONPOSTED];
    assign posted_avail_o      = avail_q[csi_flow_pkg::FLOW_POSTED];
    assign cmpl_avail_o        = avail_q[csi_flow_pkg::FLOW_CMPL];
    assign nonposted_avail_o   = avail_q[csi_flow_pkg::FLOW_NONPOSTED];

endmodule

// File: logic/csi_uport_encode.sv
/*
 * Upstream encoder top level for the coherent fabric port.
 * Runs the posted/completion and non-posted encoders side by side and
 * totals the credits of each finished capsule per flow class.
 */
module csi_uport_encode #(
    parameter int CREDIT_W = 13
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Posted and completion beats
    input  csi_fabric_pkg::seg_t                   pc_data0_i,
    input  csi_fabric_pkg::seg_t                   pc_data1_i,
    input  logic [1:0]                             pc_valid_i,
    input  logic                                   pc_sop_i,
    input  logic                                   pc_eop_i,
    input  csi_flow_pkg::flow_t                    pc_flow_i,
    input  csi_fabric_pkg::hdr_t                   pc_header_i,
    input  logic [csi_flow_pkg::BEAT_CREDIT_W-1:0] pc_credits_i,
    input  logic                                   pc_rdy_i,
    output csi_fabric_pkg::seg_t                   pc_seg0_o,
    output csi_fabric_pkg::seg_t                   pc_seg1_o,
    output logic [1:0]                             pc_vld_o,
    output logic                                   pc_sop_o,
    output logic [1:0]                             pc_eop_o,
    // Non-posted capsules
    input  csi_fabric_pkg::hdr_t                   np_header_i,
    input  logic                                   np_sop_i,
    input  logic                                   np_eop_i,
    input  logic                                   np_rdy_i,
    output csi_fabric_pkg::seg_t                   np_seg_o,
    output logic                                   np_vld_o,
    output logic                                   np_sop_o,
    output logic                                   np_eop_o,
    // Credit reports
    output logic [CREDIT_W-1:0]                    posted_credits_o,
    output logic [CREDIT_W-1:0]                    cmpl_credits_o,
    output logic [CREDIT_W-1:0]                    nonposted_credits_o,
    output logic                                   posted_avail_o,
    output logic                                   cmpl_avail_o,
    output logic                                   nonposted_avail_o
);

    credit_event_if #(.CREDIT_W(CREDIT_W)) pc_evt ();
    credit_event_if #(.CREDIT_W(CREDIT_W)) np_evt ();

    posted_cmpl_encoder u_pc_enc (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_data0_i   (pc_data0_i),
        .pc_data1_i   (pc_data1_i),
        .pc_valid_i   (pc_valid_i),
        .pc_sop_i     (pc_sop_i),
        .pc_eop_i     (pc_eop_i),
        .pc_flow_i    (pc_flow_i),
        .pc_header_i  (pc_header_i),
        .pc_credits_i (pc_credits_i),
        .pc_rdy_i     (pc_rdy_i),
        .pc_seg0_o    (pc_seg0_o),
        .pc_seg1_o    (pc_seg1_o),
        .pc_vld_o     (pc_vld_o),
        .pc_sop_o     (pc_sop_o),
        .pc_eop_o     (pc_eop_o),
        .evt_o        (pc_evt)
    );

    nonposted_encoder u_np_enc (
        .clk         (clk),
        .rst_n       (rst_n),
        .np_header_i (np_header_i),
        .np_sop_i    (np_sop_i),
        .np_eop_i    (np_eop_i),
        .np_rdy_i    (np_rdy_i),
        .np_seg_o    (np_seg_o),
        .np_vld_o    (np_vld_o),
        .np_sop_o    (np_sop_o),
        .np_eop_o    (np_eop_o),
        .evt_o       (np_evt)
    );

    credit_ledger #(.CREDIT_W(CREDIT_W)) u_ledger (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pc_evt_i            (pc_evt),
        .np_evt_i            (np_evt),
        .posted_credits_o    (posted_credits_o),
        .cmpl_credits_o      (cmpl_credits_o),
        .nonposted_credits_o (nonposted_credits_o),
        .posted_avail_o      (posted_avail_o),
        .cmpl_avail_o        (cmpl_avail_o),
        .nonposted_avail_o   (nonposted_avail_o)
    );

endmodule

// File: bench/tb_csi_uport_encode.sv
/*
 * Testbench for the upstream encoder top level.
 * Drives posted, completion and non-posted capsules, predicts every output
 * beat and credit report from the segment and ledger rules, and checks them
 * with immediate and concurrent assertions. A watchdog bounds the run.
 */
module tb_csi_uport_encode;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CREDIT_W    = 13;
    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 120;
    localparam int WATCHDOG_NS = (8 + N_TESTS * TEST_CYCLES + 200) * 100;

    typedef struct {
        csi_fabric_pkg::seg_t seg0;
        csi_fabric_pkg::seg_t seg1;
        logic [1:0]           vld;
        logic                 sop;
        logic [1:0]           eop;
        int                   flow;
        int                   charge;
        int                   due;
    } beat_t;

    logic clk;
    logic rst_n;
    csi_fabric_pkg::seg_t pc_data0_i, pc_data1_i, pc_seg0_o, pc_seg1_o, np_seg_o;
    logic [1:0] pc_valid_i, pc_vld_o, pc_eop_o;
    logic pc_sop_i, pc_eop_i, pc_rdy_i, pc_sop_o;
    csi_flow_pkg::flow_t pc_flow_i;
    csi_fabric_pkg::hdr_t pc_header_i, np_header_i;
    logic [csi_flow_pkg::BEAT_CREDIT_W-1:0] pc_credits_i;
    logic np_sop_i, np_eop_i, np_rdy_i, np_vld_o, np_sop_o, np_eop_o;
    logic [CREDIT_W-1:0] posted_credits_o, cmpl_credits_o, nonposted_credits_o;
    logic posted_avail_o, cmpl_avail_o, nonposted_avail_o;

    // Ledger outputs indexed by flow code
    logic [3:1]          act_avail;
    logic [CREDIT_W-1:0] act_total [1:3];
    logic [3:1]          exp_avail;
    logic [3:1]          next_avail;
    int                  exp_total [1:3];
    int                  run_sum [1:3];

    beat_t pc_exp[$];
    beat_t np_exp[$];
    beat_t got;
    logic [31:0] rng;
    int pc_cnt, np_cnt, errors, errors_at_start, tests_run;
    string test_name;

    assign act_avail   = {nonposted_avail_o, posted_avail_o, cmpl_avail_o};
    assign act_total[1] = cmpl_credits_o;
    assign act_total[2] = posted_credits_o;
    assign act_total[3] = nonposted_credits_o;

    csi_uport_encode #(.CREDIT_W(CREDIT_W)) dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in the allotted time");
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_seg(output csi_fabric_pkg::seg_t s);
        for (int i = 0; i < 10; i++)
        begin
            rng = lcg_step(rng);
            s[i*32 +: 32] = rng;
        end
    endtask

    task automatic flag_mismatch(input string what, input logic [319:0] exp_v,
                                 input logic [319:0] act_v);
        errors++;
        $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    endtask

    task automatic flag_problem(input string what);
        errors++;
        $display("Failure in %s: %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    // Entered and left 5 ns after a rising edge
    task automatic send_pc(input logic sop, input logic eop, input logic vld1,
                           input csi_flow_pkg::flow_t flow, input logic [2:0] credits);
        csi_fabric_pkg::seg_t d0;
        csi_fabric_pkg::seg_t d1;
        csi_fabric_pkg::seg_t h;
        beat_t                b;
        random_seg(d0);
        random_seg(d1);
        random_seg(h);
        pc_data0_i   = d0;
        pc_data1_i   = d1;
        pc_header_i  = h[223:0];
        pc_valid_i   = {vld1, 1'b1};
        pc_sop_i     = sop;
        pc_eop_i     = eop;
        pc_flow_i    = flow;
        pc_credits_i = credits;
        do @(posedge clk); while (!pc_rdy_i);
        #5;
        pc_valid_i = 2'b00;
        pc_sop_i   = 1'b0;
        pc_eop_i   = 1'b0;
        pc_flow_i  = csi_flow_pkg::FLOW_NONE;
        // Other flow classes produce no output beat
        if (flow == csi_flow_pkg::FLOW_POSTED || flow == csi_flow_pkg::FLOW_CMPL)
        begin
            b.seg0   = sop ? {d0[95:0], h[223:0]} : d0;
            b.seg1   = d1;
            b.vld    = vld1 ? 2'b11 : 2'b01;
            b.sop    = sop;
            b.eop    = eop ? (vld1 ? 2'b10 : 2'b01) : 2'b00;
            b.flow   = int'(flow);
            b.charge = vld1 ? int'(credits) : 2;
            b.due    = pc_cnt + 2;
            pc_exp.push_back(b);
        end
    endtask

    task automatic send_np();
        csi_fabric_pkg::seg_t h;
        beat_t                b;
        random_seg(h);
        np_header_i = h[223:0];
        np_sop_i    = 1'b1;
        np_eop_i    = 1'b1;
        do @(posedge clk); while (!np_rdy_i);
        #5;
        np_sop_i = 1'b0;
        np_eop_i = 1'b0;
        b.seg0   = {96'd0, h[223:0]};
        b.sop    = 1'b1;
        b.eop    = 2'b01;
        b.flow   = 3;
        b.charge = 2;
        b.due    = np_cnt + 2;
        np_exp.push_back(b);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((pc_exp.size() != 0 || np_exp.size() != 0) && n < 40)
        begin
            @(posedge clk);
            n++;
        end
        repeat (2) @(posedge clk);
        #5;
        if (n >= 40)
            flag_problem("expected beats never came out");
    endtask

    //////////////////////////////
    // Monitor and ledger model
    //////////////////////////////

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            exp_avail = '0;
            for (int c = 1; c <= 3; c++)
            begin
                exp_total[c] = 0;
                run_sum[c]   = 0;
            end
        end
        else
        begin
            for (int c = 1; c <= 3; c++)
            begin
                assert (act_avail[c] == exp_avail[c])
                    else flag_mismatch($sformatf("avail of class %0d", c), exp_avail[c],
                                       act_avail[c]);
                assert (int'(act_total[c]) == exp_total[c])
                    else flag_mismatch($sformatf("credits of class %0d", c), exp_total[c],
                                       act_total[c]);
            end
            next_avail = '0;
            if (pc_rdy_i)
                pc_cnt++;
            if (np_rdy_i)
                np_cnt++;
            if (pc_vld_o[0] && pc_rdy_i)
            begin
                if (pc_exp.size() == 0)
                    flag_problem("posted/completion beat came out that was never sent");
                else
                begin
                    got = pc_exp.pop_front();
                    assert (pc_seg0_o == got.seg0) else flag_mismatch("seg0", got.seg0, pc_seg0_o);
                    assert (pc_seg1_o == got.seg1) else flag_mismatch("seg1", got.seg1, pc_seg1_o);
                    assert (pc_vld_o == got.vld) else flag_mismatch("vld", got.vld, pc_vld_o);
                    assert (pc_sop_o == got.sop) else flag_mismatch("sop", got.sop, pc_sop_o);
                    assert (pc_eop_o == got.eop) else flag_mismatch("eop", got.eop, pc_eop_o);
                    assert (pc_cnt == got.due) else flag_mismatch("pc latency", got.due, pc_cnt);
                    run_sum[got.flow] = got.sop ? got.charge : run_sum[got.flow] + got.charge;
                    if (got.eop != 2'b00)
                    begin
                        next_avail[got.flow] = 1'b1;
                        exp_total[got.flow]  = run_sum[got.flow];
                    end
                end
            end
            if (np_vld_o && np_rdy_i)
            begin
                if (np_exp.size() == 0)
                    flag_problem("non-posted capsule came out that was never sent");
                else
                begin
                    got = np_exp.pop_front();
                    assert (np_seg_o == got.seg0) else flag_mismatch("np seg", got.seg0, np_seg_o);
                    assert (np_sop_o == got.sop) else flag_mismatch("np sop", got.sop, np_sop_o);
                    assert (np_eop_o == got.eop[0])
                        else flag_mismatch("np eop", got.eop[0], np_eop_o);
                    assert (np_cnt == got.due) else flag_mismatch("np latency", got.due, np_cnt);
                    next_avail[got.flow] = 1'b1;
                    exp_total[got.flow]  = got.charge;
                end
            end
            exp_avail = next_avail;
        end
    end

    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !pc_rdy_i |=> ($stable(pc_seg0_o) && $stable(pc_seg1_o) && $stable(pc_vld_o) &&
                       $stable(pc_sop_o) && $stable(pc_eop_o)))
        else flag_problem("posted/completion outputs moved while ready was low");

    np_flags_together: assert property (@(posedge clk) disable iff (!rst_n)
        np_vld_o |-> (np_sop_o && np_eop_o))
        else flag_problem("non-posted beat without both sop and eop");

    posted_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        posted_avail_o |=> !posted_avail_o)
        else flag_problem("posted avail stayed high for more than one cycle");

    cmpl_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cmpl_avail_o |=> !cmpl_avail_o)
        else flag_problem("completion avail stayed high for more than one cycle");

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        rng = 32'h431d;
        {pc_cnt, np_cnt, errors, errors_at_start, tests_run} = '0;
        rst_n = 1'b0;
        {pc_data0_i, pc_data1_i, pc_header_i, np_header_i} = '0;
        {pc_valid_i, pc_sop_i, pc_eop_i, pc_credits_i, np_sop_i, np_eop_i} = '0;
        pc_flow_i = csi_flow_pkg::FLOW_NONE;
        pc_rdy_i  = 1'b1;
        np_rdy_i  = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;

        start_test("reset");
        assert ({pc_vld_o, pc_sop_o, pc_eop_o, np_vld_o, np_sop_o, np_eop_o} == '0)
            else flag_mismatch("flags after reset", 0,
                               {pc_vld_o, pc_sop_o, pc_eop_o, np_vld_o, np_sop_o, np_eop_o});
        assert (act_avail == '0) else flag_mismatch("avail after reset", 0, act_avail);
        assert ({posted_credits_o, cmpl_credits_o, nonposted_credits_o} == '0)
            else flag_mismatch("credits after reset", 0,
                               {posted_credits_o, cmpl_credits_o, nonposted_credits_o});
        idle_cycles(2);
        finish_test();

        start_test("header_insert");
        send_pc(1'b1, 1'b0, 1'b1, csi_flow_pkg::FLOW_POSTED, 3'd5);
        send_pc(1'b0, 1'b0, 1'b1, csi_flow_pkg::FLOW_POSTED, 3'd3);
        send_pc(1'b0, 1'b1, 1'b0, csi_flow_pkg::FLOW_POSTED, 3'd7);
        wait_drain();
        finish_test();

        start_test("backpressure");
        fork
            begin
                send_pc(1'b1, 1'b0, 1'b1, csi_flow_pkg::FLOW_CMPL, 3'd4);
                send_pc(1'b0, 1'b0, 1'b0, csi_flow_pkg::FLOW_CMPL, 3'd1);
                send_pc(1'b0, 1'b0, 1'b1, csi_flow_pkg::FLOW_CMPL, 3'd6);
                send_pc(1'b0, 1'b1, 1'b1, csi_flow_pkg::FLOW_CMPL, 3'd3);
            end
            begin
                idle_cycles(3);
                pc_rdy_i = 1'b0;
                idle_cycles(4);
                pc_rdy_i = 1'b1;
            end
        join
        wait_drain();
        finish_test();

        start_test("credit_totals");
        send_pc(1'b1, 1'b0, 1'b0, csi_flow_pkg::FLOW_CMPL, 3'd7);
        // Beat of no flow class in the middle is dropped
        send_pc(1'b0, 1'b0, 1'b1, csi_flow_pkg::FLOW_NONE, 3'd6);
        send_pc(1'b0, 1'b1, 1'b1, csi_flow_pkg::FLOW_CMPL, 3'd6);
        wait_drain();
        send_pc(1'b1, 1'b1, 1'b1, csi_flow_pkg::FLOW_POSTED, 3'd7);
        wait_drain();
        send_pc(1'b1, 1'b0, 1'b0, csi_flow_pkg::FLOW_POSTED, 3'd1);
        send_pc(1'b0, 1'b1, 1'b0, csi_flow_pkg::FLOW_POSTED, 3'd1);
        wait_drain();
        finish_test();

        start_test("nonposted");
        for (int i = 0; i < 3; i++)
        begin
            send_np();
            idle_cycles(2);
        end
        wait_drain();
        finish_test();

        start_test("concurrent");
        fork
            begin
                send_pc(1'b1, 1'b0, 1'b1, csi_flow_pkg::FLOW_POSTED, 3'd2);
                send_pc(1'b0, 1'b0, 1'b1, csi_flow_pkg::FLOW_POSTED, 3'd5);
                send_pc(1'b0, 1'b1, 1'b0, csi_flow_pkg::FLOW_POSTED, 3'd4);
            end
            begin
                idle_cycles(1);
                send_np();
                idle_cycles(1);
                send_np();
            end
        join
        wait_drain();
        finish_test();

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: project.f
logic/csi_fabric_pkg.sv
logic/csi_flow_pkg.sv
logic/credit_event_if.sv
logic/posted_cmpl_encoder.sv
logic/nonposted_encoder.sv
logic/credit_ledger.sv
logic/csi_uport_encode.sv
bench/tb_csi_uport_encode.sv

// File: Makefile
# Verilator simulation of the upstream encoder testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_csi_uport_encode -f project.f
	./obj_dir/Vtb_csi_uport_encode | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
